/* dcache.f */
dcache_pkg.sv
dcache_tag_array.sv
dcache_data_array.sv
dcache_victim_select.sv
dcache_ctrl.sv
dcache_mem_port.sv
dcache.sv
dcache_checker.sv
dcache_tb.sv

/* dcache.sv */
module dcache (
  input  logic                 clock,
  input  logic                 reset_n,
  input  logic                 cpu_valid,
  output logic                 cpu_ready,
  input  dcache_pkg::cpu_req_t cpu_req,
  output logic                 cpu_done,
  output dcache_pkg::word_t    cpu_rdata,
  output logic                 mem_valid,
  input  logic                 mem_ready,
  output dcache_pkg::mem_req_t mem_req,
  input  logic                 mem_done,
  input  dcache_pkg::line_t    mem_rdata
);

  logic                 tag_read_en;
  logic                 tag_write_en;
  dcache_pkg::index_t   tag_read_index;
  dcache_pkg::index_t   tag_write_index;
  dcache_pkg::tag_set_t tag_write_set;
  dcache_pkg::tag_set_t tag_set_rd;
  logic                 data_read_en;
  logic                 data_write_en;
  dcache_pkg::way_oh_t  data_way;
  dcache_pkg::bank_oh_t data_bank_en;
  dcache_pkg::index_t   data_index;
  dcache_pkg::line_t    data_write_line;
  dcache_pkg::line_t    data_write_mask;
  dcache_pkg::line_t    data_read_line;
  dcache_pkg::way_oh_t  victim_way;
  logic                 victim_dirty;
  dcache_pkg::tag_t     victim_tag;
  logic                 issue_write_back;
  logic                 issue_fetch;
  dcache_pkg::addr_t    wb_addr;
  dcache_pkg::line_t    wb_line;
  dcache_pkg::addr_t    fetch_addr;
  logic                 mem_busy;

  dcache_ctrl i_ctrl (.*);

  dcache_tag_array i_tag_array (
    .clock       (clock),
    .reset_n     (reset_n),
    .read_en     (tag_read_en),
    .read_index  (tag_read_index),
    .write_en    (tag_write_en),
    .write_index (tag_write_index),
    .write_set   (tag_write_set),
    .read_set    (tag_set_rd)
  );

  dcache_data_array i_data_array (
    .clock      (clock),
    .reset_n    (reset_n),
    .read_en    (data_read_en),
    .write_en   (data_write_en),
    .way        (data_way),
    .bank_en    (data_bank_en),
    .index      (data_index),
    .write_line (data_write_line),
    .write_mask (data_write_mask),
    .read_line  (data_read_line)
  );

  dcache_victim_select i_victim_select (
    .clock        (clock),
    .reset_n      (reset_n),
    .set          (tag_set_rd),
    .victim_way   (victim_way),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag)
  );

  dcache_mem_port i_mem_port (.*);

endmodule

/* dcache_checker.sv */
module dcache_checker (
  input  logic                 clock,
  input  logic                 reset_n,
  input  logic                 cpu_valid,
  input  logic                 cpu_ready,
  input  dcache_pkg::cpu_req_t cpu_req,
  input  logic                 cpu_done,
  input  dcache_pkg::word_t    cpu_rdata,
  input  logic                 mem_valid,
  input  logic                 mem_ready,
  input  dcache_pkg::mem_req_t mem_req,
  input  dcache_pkg::word_t    expect_rdata,
  output int                   test_count,
  output int                   error_count
);
  timeunit 1ns;
  timeprecision 1ps;

  dcache_pkg::word_t    shadow [dcache_pkg::addr_t];  // keyed by word address
  dcache_pkg::cpu_req_t req_q;
  dcache_pkg::word_t    shadow_q;  // shadow word before the request
  dcache_pkg::word_t    expect_q;
  logic                 busy;
  logic                 reset_checked;

  function automatic dcache_pkg::addr_t word_addr(dcache_pkg::addr_t addr);
    return {addr[dcache_pkg::addr_w-1:3], 3'b000};
  endfunction

  // untouched memory reads as zero
  function automatic dcache_pkg::word_t stored_word(dcache_pkg::addr_t addr);
    return shadow.exists(word_addr(addr)) ? shadow[word_addr(addr)] : '0;
  endfunction

  // ports are settled at the falling edge
  always @(negedge clock) begin
    if (!reset_n) begin
      busy          = 1'b0;
      reset_checked = 1'b0;
      test_count    = 0;
      error_count   = 0;
    end else begin
      if (!reset_checked) begin
        reset_checked = 1'b1;
        test_count++;
        if (cpu_ready !== 1'b1 || cpu_done !== 1'b0 || mem_valid !== 1'b0) begin
          error_count++;
          $display("MISMATCH at %0d ns: after reset ready=%b done=%b mem_valid=%b",
                   $time, cpu_ready, cpu_done, mem_valid);
        end else begin
          $display("test %0d: reset state ok", test_count);
        end
      end
      if (cpu_done) begin
        if (!busy) begin
          error_count++;
          $display("cpu_done pulsed at %0d ns with no request in flight", $time);
        end else begin
          busy = 1'b0;
          test_count++;
          if (req_q.write) begin
            $display("test %0d: write %h mask %h done", test_count, req_q.addr, req_q.wmask);
          end else if (cpu_rdata !== shadow_q || cpu_rdata !== expect_q) begin
            error_count++;
            $display("MISMATCH at %0d ns: read %h returned %h, shadow %h, table %h",
                     $time, req_q.addr, cpu_rdata, shadow_q, expect_q);
          end else begin
            $display("test %0d: read %h -> %h ok", test_count, req_q.addr, cpu_rdata);
          end
        end
      end
      if (cpu_valid && cpu_ready) begin  // accepted on the coming edge
        busy     = 1'b1;
        req_q    = cpu_req;
        expect_q = expect_rdata;
        shadow_q = stored_word(cpu_req.addr);
        if (cpu_req.write) begin
          shadow[word_addr(cpu_req.addr)] = (cpu_req.wdata & cpu_req.wmask) |
                                            (shadow_q & ~cpu_req.wmask);
        end
      end
      if (mem_valid && mem_ready && mem_req.addr[dcache_pkg::offset_w-1:0] != '0) begin
        error_count++;
        $display("MISMATCH at %0d ns: memory request address %h is not line aligned",
                 $time, mem_req.addr);
      end
    end
  end

endmodule

/* dcache_ctrl.sv */
module dcache_ctrl (
  input  logic                  clock,
  input  logic                  reset_n,
  input  logic                  cpu_valid,
  output logic                  cpu_ready,
  input  dcache_pkg::cpu_req_t  cpu_req,
  output logic                  cpu_done,
  output dcache_pkg::word_t     cpu_rdata,
  output logic                  tag_read_en,
  output dcache_pkg::index_t    tag_read_index,
  output logic                  tag_write_en,
  output dcache_pkg::index_t    tag_write_index,
  output dcache_pkg::tag_set_t  tag_write_set,
  input  dcache_pkg::tag_set_t  tag_set_rd,
  output logic                  data_read_en,
  output logic                  data_write_en,
  output dcache_pkg::way_oh_t   data_way,
  output dcache_pkg::bank_oh_t  data_bank_en,
  output dcache_pkg::index_t    data_index,
  output dcache_pkg::line_t     data_write_line,
  output dcache_pkg::line_t     data_write_mask,
  input  dcache_pkg::line_t     data_read_line,
  input  dcache_pkg::way_oh_t   victim_way,
  input  logic                  victim_dirty,
  input  dcache_pkg::tag_t      victim_tag,
  output logic                  issue_write_back,
  output logic                  issue_fetch,
  output dcache_pkg::addr_t     wb_addr,
  output dcache_pkg::line_t     wb_line,
  output dcache_pkg::addr_t     fetch_addr,
  input  logic                  mem_busy,
  input  logic                  mem_done,
  input  dcache_pkg::line_t     mem_rdata
);

  dcache_pkg::dcache_state_e state;
  dcache_pkg::dcache_state_e next_state;
  dcache_pkg::cpu_req_t      req_q;
  dcache_pkg::tag_t          req_tag;
  dcache_pkg::index_t        req_index;
  dcache_pkg::bank_t         req_bank;
  dcache_pkg::bank_oh_t      bank_oh;
  dcache_pkg::way_oh_t       hit_way;
  dcache_pkg::way_oh_t       hit_way_q;
  dcache_pkg::way_oh_t       victim_way_q;
  dcache_pkg::tag_t          victim_tag_q;
  dcache_pkg::line_t         fill_line;
  dcache_pkg::line_t         fill_line_q;
  dcache_pkg::word_t         rdata_set;
  logic                      accept;
  logic                      hit;
  logic                      hit_q;
  logic                      done_set;
  logic                      in_refill;

  assign cpu_ready = (state == dcache_pkg::idle) && !mem_busy;
  assign accept    = cpu_valid && cpu_ready;
  assign in_refill = (state == dcache_pkg::refill_read) || (state == dcache_pkg::refill_write);

  assign req_tag   = req_q.addr[dcache_pkg::addr_w-1 -: dcache_pkg::tag_w];
  assign req_index = req_q.addr[dcache_pkg::offset_w +: dcache_pkg::index_w];
  assign req_bank  = req_q.addr[dcache_pkg::offset_w-1 -: dcache_pkg::bank_w];
  assign bank_oh   = dcache_pkg::bank_oh_t'(1) << req_bank;

  assign hit_way[0] = tag_set_rd.way0.valid && (tag_set_rd.way0.tag == req_tag);
  assign hit_way[1] = tag_set_rd.way1.valid && (tag_set_rd.way1.tag == req_tag);
  assign hit        = |hit_way;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state        <= dcache_pkg::idle;
      hit_q        <= 1'b0;
      hit_way_q    <= '0;
      victim_way_q <= '0;
      cpu_done     <= 1'b0;
    end else begin
      state    <= next_state;
      cpu_done <= done_set;
      if (state == dcache_pkg::lookup) begin  // freeze lookup result, lfsr keeps moving
        hit_q        <= hit;
        hit_way_q    <= hit_way;
        victim_way_q <= victim_way;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) req_q <= cpu_req;
    if (state == dcache_pkg::lookup) victim_tag_q <= victim_tag;
    if (state == dcache_pkg::read_mem && mem_done) fill_line_q <= fill_line;
    if (done_set) cpu_rdata <= req_q.write ? '0 : rdata_set;
  end

  always_comb begin
    next_state = state;
    case (state)
      dcache_pkg::idle: if (accept) next_state = dcache_pkg::lookup;
      dcache_pkg::lookup: begin
        if (hit) begin
          next_state = req_q.write ? dcache_pkg::write_cache : dcache_pkg::read_cache;
        end else if (victim_dirty) begin
          next_state = dcache_pkg::read_cache;  // read the victim line first
        end else begin
          next_state = dcache_pkg::read_mem;
        end
      end
      dcache_pkg::write_cache: next_state = dcache_pkg::idle;
      dcache_pkg::read_cache:  next_state = hit_q ? dcache_pkg::idle : dcache_pkg::write_mem;
      dcache_pkg::write_mem:   if (mem_done) next_state = dcache_pkg::read_mem;
      dcache_pkg::read_mem: begin
        if (mem_done) begin
          next_state = req_q.write ? dcache_pkg::refill_write : dcache_pkg::refill_read;
        end
      end
      default: next_state = dcache_pkg::idle;  // both refill states
    endcase
  end

  // store merged into the addressed bank of the fetched line
  always_comb begin
    fill_line = mem_rdata;
    if (req_q.write) begin
      fill_line[req_bank*dcache_pkg::word_w +: dcache_pkg::word_w] =
        (req_q.wdata & req_q.wmask) |
        (mem_rdata[req_bank*dcache_pkg::word_w +: dcache_pkg::word_w] & ~req_q.wmask);
    end
  end

  assign done_set = (state == dcache_pkg::write_cache) ||
                    (state == dcache_pkg::read_cache && hit_q) ||
                    (state == dcache_pkg::read_mem && mem_done);
  assign rdata_set = (state == dcache_pkg::read_mem)
    ? mem_rdata[req_bank*dcache_pkg::word_w +: dcache_pkg::word_w]
    : data_read_line[req_bank*dcache_pkg::word_w +: dcache_pkg::word_w];

  assign tag_read_en     = accept;
  assign tag_read_index  = cpu_req.addr[dcache_pkg::offset_w +: dcache_pkg::index_w];
  assign tag_write_en    = (state == dcache_pkg::write_cache) || in_refill;
  assign tag_write_index = req_index;

  always_comb begin
    tag_write_set = tag_set_rd;  // other way unchanged
    if (state == dcache_pkg::write_cache) begin
      if (hit_way_q[1]) tag_write_set.way1.dirty = 1'b1;
      else tag_write_set.way0.dirty = 1'b1;
    end else if (victim_way_q[1]) begin
      tag_write_set.way1 = '{valid: 1'b1, dirty: req_q.write, tag: req_tag};
    end else begin
      tag_write_set.way0 = '{valid: 1'b1, dirty: req_q.write, tag: req_tag};
    end
  end

  assign data_read_en  = (state == dcache_pkg::lookup) && (hit ? !req_q.write : victim_dirty);
  assign data_write_en = (state == dcache_pkg::write_cache) || in_refill;
  assign data_index    = req_index;

  always_comb begin
    if (state == dcache_pkg::lookup) begin
      data_way = hit ? hit_way : victim_way;
    end else if (state == dcache_pkg::write_cache) begin
      data_way = hit_way_q;
    end else begin
      data_way = victim_way_q;
    end
  end

  assign data_bank_en    = (state == dcache_pkg::write_cache) ? bank_oh : '1;
  assign data_write_line = (state == dcache_pkg::write_cache)
                         ? {dcache_pkg::bank_num{req_q.wdata}} : fill_line_q;
  assign data_write_mask = (state == dcache_pkg::write_cache)
                         ? {dcache_pkg::bank_num{req_q.wmask}} : '1;

  // memory side
  assign issue_write_back = (state == dcache_pkg::read_cache) && !hit_q;
  assign issue_fetch      = (state == dcache_pkg::lookup && !hit && !victim_dirty) ||
                            (state == dcache_pkg::write_mem && mem_done);
  assign wb_addr    = {victim_tag_q, req_index, {dcache_pkg::offset_w{1'b0}}};
  assign wb_line    = data_read_line;
  assign fetch_addr = {req_q.addr[dcache_pkg::addr_w-1:dcache_pkg::offset_w],
                       {dcache_pkg::offset_w{1'b0}}};

endmodule

/* dcache_data_array.sv */
module dcache_data_array (
  input  logic                 clock,
  input  logic                 reset_n,
  input  logic                 read_en,
  input  logic                 write_en,
  input  dcache_pkg::way_oh_t  way,
  input  dcache_pkg::bank_oh_t bank_en,
  input  dcache_pkg::index_t   index,
  input  dcache_pkg::line_t    write_line,
  input  dcache_pkg::line_t    write_mask,
  output dcache_pkg::line_t    read_line
);

  dcache_pkg::line_t   way_rd [dcache_pkg::way_num];
  dcache_pkg::way_oh_t way_q;  // way of the last read

  for (genvar w = 0; w < dcache_pkg::way_num; w++) begin : g_way
    for (genvar b = 0; b < dcache_pkg::bank_num; b++) begin : g_bank
      dcache_pkg::word_t mem [dcache_pkg::set_num];
      dcache_pkg::word_t wr_word;
      dcache_pkg::word_t wr_mask;
      dcache_pkg::word_t rd_q;

      assign wr_word = write_line[b*dcache_pkg::word_w +: dcache_pkg::word_w];
      assign wr_mask = write_mask[b*dcache_pkg::word_w +: dcache_pkg::word_w];

      always_ff @(posedge clock) begin
        if (write_en && way[w] && bank_en[b]) begin
          mem[index] <= (wr_word & wr_mask) | (mem[index] & ~wr_mask);  // bit mask merge
        end
        if (read_en && way[w]) rd_q <= mem[index];
      end

      assign way_rd[w][b*dcache_pkg::word_w +: dcache_pkg::word_w] = rd_q;
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      way_q <= '0;
    end else if (read_en) begin
      way_q <= way;
    end
  end

  assign read_line = way_q[1] ? way_rd[1] : way_rd[0];

endmodule

/* dcache_mem_port.sv */
module dcache_mem_port (
  input  logic                 clock,
  input  logic                 reset_n,
  input  logic                 issue_write_back,
  input  logic                 issue_fetch,
  input  dcache_pkg::addr_t    wb_addr,
  input  dcache_pkg::line_t    wb_line,
  input  dcache_pkg::addr_t    fetch_addr,
  output logic                 mem_valid,
  input  logic                 mem_ready,
  output dcache_pkg::mem_req_t mem_req,
  input  logic                 mem_done,
  output logic                 mem_busy
);

  logic issue;

  assign issue = issue_write_back || issue_fetch;

  // valid held until the memory takes the request
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      mem_valid <= 1'b0;
    end else if (issue) begin
      mem_valid <= 1'b1;
    end else if (mem_valid && mem_ready) begin
      mem_valid <= 1'b0;
    end
  end

  // busy spans issue to done, issue wins a tie
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      mem_busy <= 1'b0;
    end else if (issue) begin
      mem_busy <= 1'b1;
    end else if (mem_done) begin
      mem_busy <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (issue_write_back) begin
      mem_req.addr  <= wb_addr;
      mem_req.wdata <= wb_line;  // dirty victim line
      mem_req.write <= 1'b1;
    end
    if (issue_fetch && !issue_write_back) begin
      mem_req.addr  <= fetch_addr;
      mem_req.wdata <= '0;
      mem_req.write <= 1'b0;
    end
  end

endmodule

/* dcache_pkg.sv */
package dcache_pkg;

  localparam int addr_w   = 32;
  localparam int word_w   = 64;
  localparam int line_w   = 512;
  localparam int bank_num = 8;
  localparam int way_num  = 2;
  localparam int tag_w    = 17;  // addr[31:15]
  localparam int index_w  = 9;   // addr[14:6]
  localparam int bank_w   = 3;   // addr[5:3]
  localparam int offset_w = 6;
  localparam int set_num  = 1 << index_w;

  typedef logic [addr_w-1:0]   addr_t;
  typedef logic [word_w-1:0]   word_t;
  typedef logic [line_w-1:0]   line_t;
  typedef logic [tag_w-1:0]    tag_t;
  typedef logic [index_w-1:0]  index_t;
  typedef logic [bank_w-1:0]   bank_t;
  typedef logic [way_num-1:0]  way_oh_t;
  typedef logic [bank_num-1:0] bank_oh_t;

  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } tag_entry_t;

  // both ways of one set, stored as a single word
  typedef struct packed {
    tag_entry_t way1;
    tag_entry_t way0;
  } tag_set_t;

  typedef struct packed {
    addr_t addr;
    word_t wdata;
    word_t wmask;  // per bit, 1 takes wdata
    logic  write;
  } cpu_req_t;

  typedef struct packed {
    addr_t addr;  // line aligned
    line_t wdata;
    logic  write;
  } mem_req_t;

  typedef enum logic [2:0] {
    idle,
    lookup,
    write_cache,
    read_cache,
    write_mem,
    read_mem,
    refill_read,
    refill_write
  } dcache_state_e;

endpackage

/* dcache_tag_array.sv */
module dcache_tag_array (
  input  logic                 clock,
  input  logic                 reset_n,
  input  logic                 read_en,
  input  dcache_pkg::index_t   read_index,
  input  logic                 write_en,
  input  dcache_pkg::index_t   write_index,
  input  dcache_pkg::tag_set_t write_set,
  output dcache_pkg::tag_set_t read_set
);

  dcache_pkg::tag_set_t           mem [dcache_pkg::set_num];
  dcache_pkg::tag_set_t           rd_q;
  logic [dcache_pkg::set_num-1:0] valid0;  // valid bits held in flops
  logic [dcache_pkg::set_num-1:0] valid1;
  logic [dcache_pkg::way_num-1:0] rd_valid_q;

  always_ff @(posedge clock) begin
    if (write_en) mem[write_index] <= write_set;  // whole set replaced
    if (read_en) rd_q <= mem[read_index];
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      valid0     <= '0;
      valid1     <= '0;
      rd_valid_q <= '0;
    end else begin
      if (write_en) begin
        valid0[write_index] <= write_set.way0.valid;
        valid1[write_index] <= write_set.way1.valid;
      end
      if (read_en) rd_valid_q <= {valid1[read_index], valid0[read_index]};
    end
  end

  // stored dirty/tag with the live valid bits
  always_comb begin
    read_set            = rd_q;
    read_set.way0.valid = rd_valid_q[0];
    read_set.way1.valid = rd_valid_q[1];
  end

endmodule

/* dcache_tb.sv */
module dcache_tb;
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    logic              write;
    dcache_pkg::addr_t addr;
    dcache_pkg::word_t data;
    dcache_pkg::word_t mask;
    dcache_pkg::word_t rdata;  // expected read data
  } test_entry_t;

  localparam int accept_timeout = 100;
  localparam int done_timeout   = 200;
  localparam int test_num       = 14;

  // index 0x10 holds tags 1, 2 and 3 in the last group
  localparam test_entry_t test_table [test_num] = '{
    '{1'b0, 32'h0000_1040, 64'h0, 64'h0, 64'h0},
    '{1'b1, 32'h0000_2008, 64'h1111_2222_3333_4444, 64'hffff_ffff_ffff_ffff, 64'h0},
    '{1'b1, 32'h0000_2008, 64'haaaa_bbbb_cccc_dddd, 64'h0000_0000_ffff_ffff, 64'h0},
    '{1'b0, 32'h0000_2008, 64'h0, 64'h0, 64'h1111_2222_cccc_dddd},
    '{1'b1, 32'h0000_3010, 64'h0123_4567_89ab_cdef, 64'h00ff_00ff_00ff_00ff, 64'h0},
    '{1'b0, 32'h0000_3018, 64'h0, 64'h0, 64'h0},
    '{1'b0, 32'h0000_3010, 64'h0, 64'h0, 64'h0023_0067_00ab_00ef},
    '{1'b1, 32'h0000_8408, 64'ha1a1_a1a1_a1a1_a1a1, 64'hffff_ffff_ffff_ffff, 64'h0},
    '{1'b1, 32'h0001_0408, 64'hb2b2_b2b2_b2b2_b2b2, 64'hffff_ffff_0000_ffff, 64'h0},
    '{1'b1, 32'h0001_8408, 64'hc3c3_c3c3_c3c3_c3c3, 64'h0f0f_0f0f_0f0f_0f0f, 64'h0},
    '{1'b0, 32'h0000_8408, 64'h0, 64'h0, 64'ha1a1_a1a1_a1a1_a1a1},
    '{1'b0, 32'h0001_0408, 64'h0, 64'h0, 64'hb2b2_b2b2_0000_b2b2},
    '{1'b0, 32'h0001_8408, 64'h0, 64'h0, 64'h0303_0303_0303_0303},
    '{1'b0, 32'h0000_8400, 64'h0, 64'h0, 64'h0}
  };

  logic                 clock = 1'b0;
  logic                 reset_n;
  logic                 cpu_valid;
  logic                 cpu_ready;
  dcache_pkg::cpu_req_t cpu_req;
  logic                 cpu_done;
  dcache_pkg::word_t    cpu_rdata;
  logic                 mem_valid;
  logic                 mem_ready;
  dcache_pkg::mem_req_t mem_req;
  logic                 mem_done;
  dcache_pkg::line_t    mem_rdata;
  dcache_pkg::word_t    expect_word;
  int                   test_count;
  int                   error_count;
  int                   seed = 32'h6fb9;
  dcache_pkg::line_t    line_mem [dcache_pkg::addr_t];  // backing memory, zero if absent

  always #5 clock = ~clock;

  dcache i_dut (
    .clock     (clock),
    .reset_n   (reset_n),
    .cpu_valid (cpu_valid),
    .cpu_ready (cpu_ready),
    .cpu_req   (cpu_req),
    .cpu_done  (cpu_done),
    .cpu_rdata (cpu_rdata),
    .mem_valid (mem_valid),
    .mem_ready (mem_ready),
    .mem_req   (mem_req),
    .mem_done  (mem_done),
    .mem_rdata (mem_rdata)
  );

  dcache_checker i_checker (
    .clock        (clock),
    .reset_n      (reset_n),
    .cpu_valid    (cpu_valid),
    .cpu_ready    (cpu_ready),
    .cpu_req      (cpu_req),
    .cpu_done     (cpu_done),
    .cpu_rdata    (cpu_rdata),
    .mem_valid    (mem_valid),
    .mem_ready    (mem_ready),
    .mem_req      (mem_req),
    .expect_rdata (expect_word),
    .test_count   (test_count),
    .error_count  (error_count)
  );

  function automatic int random_delay();
    return $unsigned($random(seed)) % 4;
  endfunction

  // valid is already high, returns on the accepting edge
  task automatic wait_accept(output bit ok);
    int cycles;
    ok     = 1'b0;
    cycles = 0;
    while (!ok && cycles < accept_timeout) begin
      @(negedge clock);
      cycles++;
      if (cpu_ready) ok = 1'b1;
    end
    @(posedge clock);
  endtask

  task automatic wait_done(output bit ok);
    int cycles;
    ok     = 1'b0;
    cycles = 0;
    while (!ok && cycles < done_timeout) begin
      @(negedge clock);
      cycles++;
      if (cpu_done) ok = 1'b1;
    end
    @(posedge clock);
  endtask

  // one line transaction at a time, random ready and done delays
  initial begin : memory_model
    dcache_pkg::mem_req_t req;
    int                   delay;
    mem_ready <= 1'b0;
    mem_done  <= 1'b0;
    mem_rdata <= '0;
    forever begin
      @(negedge clock);
      if (reset_n && mem_valid) begin
        req   = mem_req;  // held stable while valid
        delay = random_delay();
        repeat (delay + 1) @(posedge clock);
        mem_ready <= 1'b1;
        @(posedge clock);  // request taken here
        mem_ready <= 1'b0;
        delay = random_delay();
        repeat (delay) @(posedge clock);
        if (req.write) begin
          line_mem[req.addr] = req.wdata;
          mem_rdata <= '0;
        end else begin
          mem_rdata <= line_mem.exists(req.addr) ? line_mem[req.addr] : '0;
        end
        mem_done <= 1'b1;
        @(posedge clock);
        mem_done <= 1'b0;
      end
    end
  end

  initial begin : stimulus
    bit ok;
    bit aborted;
    int i;
    ok          = 1'b0;
    aborted     = 1'b0;
    reset_n     <= 1'b0;
    cpu_valid   <= 1'b0;
    cpu_req     <= '0;
    expect_word <= '0;
    repeat (4) @(posedge clock);
    reset_n <= 1'b1;
    repeat (2) @(posedge clock);
    i = 0;
    while (i < test_num && !aborted) begin
      cpu_valid   <= 1'b1;
      cpu_req     <= '{addr: test_table[i].addr, wdata: test_table[i].data,
                       wmask: test_table[i].mask, write: test_table[i].write};
      expect_word <= test_table[i].rdata;
      wait_accept(ok);
      cpu_valid <= 1'b0;
      if (!ok) begin
        $display("request %0d was not accepted within %0d cycles", i, accept_timeout);
        aborted = 1'b1;
      end else begin
        wait_done(ok);
        if (!ok) begin
          $display("request %0d got no cpu_done within %0d cycles", i, done_timeout);
          aborted = 1'b1;
        end
      end
      i++;
    end
    repeat (2) @(posedge clock);
    $display("tests: %0d, errors: %0d", test_count, error_count);
    if (!aborted && error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* dcache_victim_select.sv */
module dcache_victim_select (
  input  logic                 clock,
  input  logic                 reset_n,
  input  dcache_pkg::tag_set_t set,
  output dcache_pkg::way_oh_t  victim_way,
  output logic                 victim_dirty,
  output dcache_pkg::tag_t     victim_tag
);

  logic [7:0]             lfsr;
  dcache_pkg::tag_entry_t pick;

  // x^8 + x^6 + x^5 + x^4 + 1, free running
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      lfsr <= 8'hff;
    end else begin
      lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
    end
  end

  always_comb begin
    if (!set.way0.valid) begin
      victim_way = 2'b01;
    end else if (!set.way1.valid) begin
      victim_way = 2'b10;
    end else begin
      victim_way = lfsr[0] ? 2'b10 : 2'b01;  // set full, random way
    end
  end

  assign pick         = victim_way[1] ? set.way1 : set.way0;
  assign victim_dirty = pick.valid & pick.dirty;
  assign victim_tag   = pick.tag;

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module dcache_tb -f dcache.f
output=$(./obj_dir/Vdcache_tb)
echo "$output"

if echo "$output" | grep -qx "Everything OK"; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
